/* include/nd120_cfg.svh */
// ND120 board configuration
// Bus width, program counter reset value and installation number
`ifndef ND120_CFG_SVH
`define ND120_CFG_SVH

// Multiplexed address/data lines on the ND-100 bus
`define ND_BUS_W 24

// PC value after reset
`define ND_PC_RESET 12'd0

// Installation number tied on the board
`define ND_INSTALL_NUM 8'd123

`endif

/* source/nd_bus_pkg.sv */
// ND-100 bus side types
// Cycle kind and bus master sequencing
`default_nettype none

package nd_bus_pkg;

  // Direction of one bus cycle
  typedef enum logic {
    BUS_READ  = 1'b0,  // binput_n low
    BUS_WRITE = 1'b1   // bdap_n driven by master
  } bus_kind_e;

  // Bus master sequencing
  typedef enum logic [1:0] {
    BS_IDLE = 2'd0,  // Waiting for start
    BS_ADDR = 2'd1,  // bapr_n low, address on bd
    BS_WAIT = 2'd2,  // Waiting for bdry_n
    BS_DONE = 2'd3   // Done pulse cycle
  } bus_state_e;

endpackage

`default_nettype wire

/* source/nd_cpu_pkg.sv */
// ND120 CPU side types
// Opcodes, io subcodes, instruction word views and ALU operations
`default_nettype none

package nd_cpu_pkg;

  // Major opcode in bits 15:12, unlisted codes run as no-op
  typedef enum logic [3:0] {
    OP_LDA = 4'd1,   // acc = mem
    OP_STA = 4'd2,   // mem = acc
    OP_ADD = 4'd3,   // acc += mem
    OP_AND = 4'd4,   // acc &= mem
    OP_JMP = 4'd5,   // pc = addr
    OP_IOG = 4'd15   // Register/io group
  } opcode_e;

  // Subcode of the io group in bits 11:8
  typedef enum logic [3:0] {
    IO_LDI = 4'd0,  // acc = imm
    IO_INR = 4'd1,  // acc = installation number
    IO_IOX = 4'd2,  // lamps = acc[4:0]
    IO_HLT = 4'd3   // Stop
  } io_sub_e;

  // One instruction word, decoded in two formats
  typedef union packed {
    struct packed {
      opcode_e     op;
      logic [11:0] addr;  // Word address
    } mem;
    struct packed {
      opcode_e    op;
      io_sub_e    sub;
      logic [7:0] imm;  // Zero-extended immediate
    } io;
  } instr_u;

  // ALU function
  typedef enum logic [1:0] {
    ALU_PASS = 2'd0,  // Operand through
    ALU_ADD  = 2'd1,  // Wrapping 16-bit add
    ALU_AND  = 2'd2   // Bitwise and
  } alu_op_e;

endpackage

`default_nettype wire

/* source/nd_decode.sv */
// Instruction decode
// Latches the fetched word and registers its control set a cycle later
`timescale 1ns/1ps
`default_nettype none

module nd_decode import nd_cpu_pkg::*;
(
  input  wire         sysclk,
  input  wire         rst,
  input  wire         ir_load,     // Fetch completed
  input  wire  [15:0] ir_word,     // Fetched word
  output logic        dec_valid,   // Controls ready, one cycle
  output alu_op_e     dec_alu,
  output logic        dec_read,    // Operand read cycle
  output logic        dec_write,   // Store cycle
  output logic        dec_jump,
  output logic        dec_io_we,
  output logic        dec_acc_we,
  output logic        dec_halt,
  output logic [11:0] dec_addr,
  output logic [7:0]  dec_imm,
  output logic        dec_use_inr  // Operand is installation number
);

  instr_u ir;       // Instruction register
  logic   pending;  // Word latched, not yet decoded

  always_ff @(posedge sysclk)
  begin
    if (ir_load)
    begin
      ir <= ir_word;
    end
  end

  always_ff @(posedge sysclk)
  begin
    if (rst)
    begin
      pending   <= 1'b0;
      dec_valid <= 1'b0;
    end
    else
    begin
      pending   <= ir_load;
      dec_valid <= pending;  // Pulse one cycle after the latch
    end
  end

  always_ff @(posedge sysclk)
  begin
    if (pending)
    begin
      dec_alu     <= ALU_PASS;  // Defaults give a plain no-op
      dec_read    <= 1'b0;
      dec_write   <= 1'b0;
      dec_jump    <= 1'b0;
      dec_io_we   <= 1'b0;
      dec_acc_we  <= 1'b0;
      dec_halt    <= 1'b0;
      dec_use_inr <= 1'b0;
      dec_addr    <= ir.mem.addr;  // Memory view
      dec_imm     <= ir.io.imm;    // Io view
      case (ir.mem.op)
        OP_LDA:
        begin
          dec_read   <= 1'b1;
          dec_acc_we <= 1'b1;
        end
        OP_STA: dec_write <= 1'b1;
        OP_ADD:
        begin
          dec_read   <= 1'b1;
          dec_acc_we <= 1'b1;
          dec_alu    <= ALU_ADD;
        end
        OP_AND:
        begin
          dec_read   <= 1'b1;
          dec_acc_we <= 1'b1;
          dec_alu    <= ALU_AND;
        end
        OP_JMP: dec_jump <= 1'b1;
        OP_IOG:
        begin
          case (ir.io.sub)
            IO_LDI: dec_acc_we <= 1'b1;  // Immediate through ALU
            IO_INR:
            begin
              dec_acc_we  <= 1'b1;
              dec_use_inr <= 1'b1;
            end
            IO_IOX: dec_io_we <= 1'b1;
            IO_HLT: dec_halt  <= 1'b1;
            default: ;  // Unknown subcode, PC only
          endcase
        end
        default: ;  // Unknown opcode, PC only
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/nd_bus_master.sv */
// ND-100 bus master
// Runs one read or write cycle per start strobe, all pins registered
`timescale 1ns/1ps
`default_nettype none
`include "nd120_cfg.svh"

module nd_bus_master import nd_bus_pkg::*;
(
  input  wire                  sysclk,
  input  wire                  rst,
  input  wire                  bus_start,   // One-cycle request
  input  bus_kind_e            bus_kind,
  input  wire  [11:0]          bus_addr,    // Word address
  input  wire  [15:0]          bus_wdata,
  input  wire  [`ND_BUS_W-1:0] bd_n_in,     // Active-low data from bus
  input  wire                  bdry_n_in,   // Data ready
  output logic                 bus_done,    // One-cycle completion
  output logic [15:0]          bus_rdata,
  output logic [`ND_BUS_W-1:0] bd_n_out,    // Active-low address/data
  output logic                 bapr_n_out,  // Address present
  output logic                 bdap_n_out,  // Data present
  output logic                 bmem_n,      // Memory cycle
  output logic                 binput_n     // Read cycle
);

  bus_state_e state;
  bus_kind_e  kind_q;  // Kind of the running cycle

  always_ff @(posedge sysclk)
  begin
    if (rst)
    begin
      state      <= BS_IDLE;
      bus_done   <= 1'b0;
      bd_n_out   <= '1;  // Released bus is all ones
      bapr_n_out <= 1'b1;
      bdap_n_out <= 1'b1;
      bmem_n     <= 1'b1;
      binput_n   <= 1'b1;
    end
    else
    begin
      bus_done   <= 1'b0;
      bapr_n_out <= 1'b1;  // Address strobe lasts one cycle
      case (state)
        BS_IDLE:
        begin
          if (bus_start)
          begin
            state      <= BS_ADDR;
            bapr_n_out <= 1'b0;
            bmem_n     <= 1'b0;
            binput_n   <= (bus_kind == BUS_WRITE);  // Low through a read
            bd_n_out   <= ~{{(`ND_BUS_W-12){1'b0}}, bus_addr};
          end
        end
        BS_ADDR:
        begin
          state <= BS_WAIT;
          if (kind_q == BUS_WRITE)
          begin
            bdap_n_out <= 1'b0;
            bd_n_out   <= ~{{(`ND_BUS_W-16){1'b0}}, bus_wdata};
          end
          else
          begin
            bd_n_out <= '1;  // Let the memory drive
          end
        end
        BS_WAIT:
        begin
          if (!bdry_n_in)  // Memory may stall here any time
          begin
            state      <= BS_DONE;
            bus_done   <= 1'b1;
            bdap_n_out <= 1'b1;
            bmem_n     <= 1'b1;
            binput_n   <= 1'b1;
            bd_n_out   <= '1;
          end
        end
        default: state <= BS_IDLE;  // BS_DONE, done pulse shows now
      endcase
    end
  end

  // Payload regs
  always_ff @(posedge sysclk)
  begin
    if (state == BS_IDLE && bus_start)
    begin
      kind_q <= bus_kind;
    end
    if (state == BS_WAIT && !bdry_n_in && kind_q == BUS_READ)
    begin
      bus_rdata <= ~bd_n_in[15:0];  // Data in low bits
    end
  end

endmodule

`default_nettype wire

/* source/nd_execute.sv */
// Instruction sequencer and ALU
// Fetches, runs operand and store cycles, issues the writeback strobes
`timescale 1ns/1ps
`default_nettype none

module nd_execute import nd_bus_pkg::*, nd_cpu_pkg::*;
(
  input  wire         sysclk,
  input  wire         rst,
  input  wire         dec_valid,
  input  alu_op_e     dec_alu,
  input  wire         dec_read,
  input  wire         dec_write,
  input  wire         dec_jump,
  input  wire         dec_io_we,
  input  wire         dec_acc_we,
  input  wire         dec_halt,
  input  wire  [11:0] dec_addr,
  input  wire  [7:0]  dec_imm,
  input  wire         dec_use_inr,
  input  wire  [15:0] acc,
  input  wire  [11:0] pc,
  input  wire         run,
  input  wire  [7:0]  inr,        // Installation number
  input  wire         bus_done,
  input  wire  [15:0] bus_rdata,
  output logic        ir_load,    // Fetched word valid
  output logic        bus_start,
  output bus_kind_e   bus_kind,
  output logic [11:0] bus_addr,
  output logic [15:0] bus_wdata,
  output logic        acc_we,
  output logic [15:0] acc_next,
  output logic        pc_inc,
  output logic        pc_load,
  output logic [11:0] pc_target,
  output logic        io_we,
  output logic        halt
);

  localparam logic [2:0] S_FETCH = 3'd0;  // Issue fetch
  localparam logic [2:0] S_WFETCH = 3'd1;  // Fetch on the bus
  localparam logic [2:0] S_WDEC = 3'd2;  // Wait for decode
  localparam logic [2:0] S_OPER = 3'd3;  // Operand read or store
  localparam logic [2:0] S_WRITE = 3'd4;  // Writeback strobes high
  localparam logic [2:0] S_HALT = 3'd5;

  logic [2:0]  state;
  logic [15:0] operand;
  logic [15:0] alu_y;

  // Word reaches decode the cycle the fetch completes
  assign ir_load = (state == S_WFETCH) && bus_done;

  always_comb
  begin
    if (dec_use_inr)
      operand = {8'h00, inr};
    else if (dec_read)
      operand = bus_rdata;  // Valid during bus_done
    else
      operand = {8'h00, dec_imm};
    case (dec_alu)
      ALU_ADD: alu_y = acc + operand;  // Wraps at 16 bits
      ALU_AND: alu_y = acc & operand;
      default: alu_y = operand;
    endcase
  end

  always_ff @(posedge sysclk)
  begin
    if (rst)
    begin
      state     <= S_FETCH;
      bus_start <= 1'b0;
      acc_we    <= 1'b0;
      pc_inc    <= 1'b0;
      pc_load   <= 1'b0;
      io_we     <= 1'b0;
      halt      <= 1'b0;
    end
    else
    begin
      bus_start <= 1'b0;  // All strobes are single-cycle
      acc_we    <= 1'b0;
      pc_inc    <= 1'b0;
      pc_load   <= 1'b0;
      io_we     <= 1'b0;
      halt      <= 1'b0;
      case (state)
        S_FETCH:
        begin
          if (run)
          begin
            bus_start <= 1'b1;
            bus_kind  <= BUS_READ;
            bus_addr  <= pc;
            state     <= S_WFETCH;
          end
          else
          begin
            state <= S_HALT;
          end
        end
        S_WFETCH: if (bus_done) state <= S_WDEC;
        S_WDEC:
        begin
          if (dec_valid)
          begin
            bus_addr  <= dec_addr;
            bus_wdata <= acc;  // Store data
            if (dec_read || dec_write)
            begin
              bus_start <= 1'b1;
              bus_kind  <= dec_write ? BUS_WRITE : BUS_READ;
              state     <= S_OPER;
            end
            else
            begin
              acc_we    <= dec_acc_we;  // LDI, INR
              acc_next  <= alu_y;
              io_we     <= dec_io_we;
              halt      <= dec_halt;
              pc_load   <= dec_jump;
              pc_inc    <= !dec_jump;
              pc_target <= dec_addr;
              state     <= S_WRITE;
            end
          end
        end
        S_OPER:
        begin
          if (bus_done)
          begin
            acc_we   <= dec_acc_we;  // Clear for STA
            acc_next <= alu_y;
            pc_inc   <= 1'b1;
            state    <= S_WRITE;
          end
        end
        S_WRITE: state <= S_FETCH;
        default: state <= S_HALT;  // Held until reset
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/nd_result.sv */
// Architectural state
// Accumulator, program counter, lamp register and run flag
`timescale 1ns/1ps
`default_nettype none
`include "nd120_cfg.svh"

module nd_result
(
  input  wire         sysclk,
  input  wire         rst,
  input  wire         acc_we,
  input  wire  [15:0] acc_next,
  input  wire         pc_inc,
  input  wire         pc_load,    // Jump
  input  wire  [11:0] pc_target,
  input  wire         io_we,      // Lamps from acc
  input  wire         halt,
  output logic [15:0] acc,
  output logic [11:0] pc,
  output logic [4:0]  lamp,
  output logic        run
);

  always_ff @(posedge sysclk)
  begin
    if (rst)
    begin
      acc  <= 16'h0000;
      pc   <= `ND_PC_RESET;
      lamp <= 5'd0;
      run  <= 1'b1;  // Start fetching after reset
    end
    else
    begin
      if (acc_we)
        acc <= acc_next;
      if (pc_load)
        pc <= pc_target;
      else if (pc_inc)
        pc <= pc + 12'd1;  // Wraps at 12 bits
      if (io_we)
        lamp <= acc[4:0];
      if (halt)
        run <= 1'b0;  // Stays stopped until reset
    end
  end

endmodule

`default_nettype wire

/* source/nd3202d_board.sv */
// ND-3202D style board core
// Decode, execute, result and bus master wired together
`timescale 1ns/1ps
`default_nettype none
`include "nd120_cfg.svh"

module nd3202d_board import nd_bus_pkg::*, nd_cpu_pkg::*;
(
  input  wire                  sysclk,
  input  wire                  rst,
  input  wire  [7:0]           inr,
  input  wire  [`ND_BUS_W-1:0] bd_n_in,
  input  wire                  bdry_n_in,
  output wire  [`ND_BUS_W-1:0] bd_n_out,
  output wire                  bapr_n_out,
  output wire                  bdap_n_out,
  output wire                  bmem_n,
  output wire                  binput_n,
  output wire                  run,
  output wire  [4:0]           lamp,
  output wire  [11:0]          pc
);

  wire        ir_load, dec_valid, dec_read, dec_write, dec_jump;
  wire        dec_io_we, dec_acc_we, dec_halt, dec_use_inr;
  alu_op_e    dec_alu;
  wire [11:0] dec_addr, bus_addr, pc_target;
  wire [7:0]  dec_imm;
  wire        bus_start, bus_done, acc_we, pc_inc, pc_load, io_we, halt;
  bus_kind_e  bus_kind;
  wire [15:0] bus_wdata, bus_rdata, acc, acc_next;

  nd_decode u_decode (.sysclk, .rst, .ir_load, .ir_word(bus_rdata), .dec_valid, .dec_alu,
    .dec_read, .dec_write, .dec_jump, .dec_io_we, .dec_acc_we, .dec_halt, .dec_addr,
    .dec_imm, .dec_use_inr);

  nd_execute u_execute (.sysclk, .rst, .dec_valid, .dec_alu, .dec_read, .dec_write,
    .dec_jump, .dec_io_we, .dec_acc_we, .dec_halt, .dec_addr, .dec_imm, .dec_use_inr,
    .acc, .pc, .run, .inr, .bus_done, .bus_rdata, .ir_load, .bus_start, .bus_kind,
    .bus_addr, .bus_wdata, .acc_we, .acc_next, .pc_inc, .pc_load, .pc_target, .io_we, .halt);

  nd_result u_result (.sysclk, .rst, .acc_we, .acc_next, .pc_inc, .pc_load, .pc_target,
    .io_we, .halt, .acc, .pc, .lamp, .run);

  nd_bus_master u_bus (.sysclk, .rst, .bus_start, .bus_kind, .bus_addr, .bus_wdata,
    .bd_n_in, .bdry_n_in, .bus_done, .bus_rdata, .bd_n_out, .bapr_n_out, .bdap_n_out,
    .bmem_n, .binput_n);

endmodule

`default_nettype wire

/* source/nd120_top.sv */
// ND120 FPGA top level
// Board pins, constant ties and active-low LED drive around the CPU core
`timescale 1ns/1ps
`default_nettype none
`include "nd120_cfg.svh"

module nd120_top
(
  input  wire                  sysclk,
  input  wire                  rst,         // Synchronous, active high
  input  wire  [`ND_BUS_W-1:0] bd_n_in,
  input  wire                  bapr_n_in,   // Pin only, sole bus master
  input  wire                  bdap_n_in,   // Pin only, sole bus master
  input  wire                  bdry_n_in,
  output wire  [`ND_BUS_W-1:0] bd_n_out,
  output wire                  bapr_n_out,
  output wire                  bdap_n_out,
  output wire                  bmem_n,
  output wire                  binput_n,
  output wire                  run_n,
  output wire  [6:0]           led,         // Active low
  output wire  [11:0]          csa          // Debug, current PC
);

  wire [7:0]  inr = `ND_INSTALL_NUM;  // Installation number tie
  wire        run;
  wire [4:0]  lamp;
  wire        bus_active = ~bmem_n;  // Memory cycle in progress

  assign run_n    = ~run;
  assign led[0]   = ~run;
  assign led[1]   = ~bus_active;
  assign led[6:2] = ~lamp;  // IOX lamp bits

  nd3202d_board u_board (.sysclk, .rst, .inr, .bd_n_in, .bdry_n_in, .bd_n_out,
    .bapr_n_out, .bdap_n_out, .bmem_n, .binput_n, .run, .lamp, .pc(csa));

endmodule

`default_nettype wire

/* tests/tb_nd120.sv */
// ND120 top level testbench
// Random programs on a stalling memory model, checked against a reference interpreter
`timescale 1ns/1ps
`default_nettype none
`include "nd120_cfg.svh"

module tb_nd120 import nd_cpu_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int N_PROGS      = 8;
  localparam int MIN_INSTR    = 20;
  localparam int MAX_INSTR    = 40;
  localparam int MAX_DELAY    = 5;   // Worst bdry stall in cycles
  localparam int IDLE_CHECK   = 50;  // Quiet cycles after halt
  localparam int HALT_LIMIT   = MAX_INSTR * 3 * (MAX_DELAY + 6);
  localparam int WATCHDOG_NS  = N_PROGS * (HALT_LIMIT + RESET_CYCLES + IDLE_CHECK + 4)
                                * CLK_PERIOD;
  localparam logic [11:0] DATA_BASE   = 12'h100;  // Data sits above the code
  localparam int          DATA_WORDS  = 64;
  localparam logic [11:0] RESULT_SLOT = 12'h140;  // INR result store

  logic                 sysclk;
  logic                 rst;
  logic [`ND_BUS_W-1:0] bd_n_in = '1;    // Released bus
  logic                 bapr_n_in;
  logic                 bdap_n_in;
  logic                 bdry_n_in = 1'b1;
  wire  [`ND_BUS_W-1:0] bd_n_out;
  wire                  bapr_n_out, bdap_n_out, bmem_n, binput_n, run_n;
  wire  [6:0]           led;
  wire  [11:0]          csa;

  logic [15:0] image [0:4095];  // Program image for the next run
  logic [15:0] mem [0:4095];    // Memory model contents
  logic [11:0] exp_addr[$];     // Reference bus address trace
  logic [11:0] exp_wr_addr[$];
  logic [15:0] exp_wr_data[$];
  logic [11:0] seen_addr[$];    // Logged by the memory model
  logic [11:0] seen_wr_addr[$];
  logic [15:0] seen_wr_data[$];
  logic [4:0]  exp_lamp;
  logic [11:0] exp_halt_pc;
  int          bapr_count = 0;

  logic        cyc_busy = 1'b0;  // Memory cycle in progress
  logic        cyc_read = 1'b1;
  logic [11:0] cyc_addr;
  int          cyc_wait;

  nd120_top DUT (.sysclk, .rst, .bd_n_in, .bapr_n_in, .bdap_n_in, .bdry_n_in, .bd_n_out,
    .bapr_n_out, .bdap_n_out, .bmem_n, .binput_n, .run_n, .led, .csa);

  initial
  begin
    sysclk = 1'b0;
    forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
  end

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected)
    begin
      $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run aborted");
  endtask

  // Idle bus, lamps off, CPU running
  task automatic check_reset_outputs(input string when);
    check_eq(32'(bapr_n_out), 32'd1, {"bapr_n_out ", when});
    check_eq(32'(bdap_n_out), 32'd1, {"bdap_n_out ", when});
    check_eq(32'(bmem_n), 32'd1, {"bmem_n ", when});
    check_eq(32'(binput_n), 32'd1, {"binput_n ", when});
    check_eq(32'(bd_n_out), 32'h00FF_FFFF, {"bd_n_out ", when});
    check_eq(32'(run_n), 32'd0, {"run_n ", when});
    check_eq(32'(led), 32'h7E, {"led ", when});  // Lamps 0, bus idle, run on
    check_eq(32'(csa), 32'(`ND_PC_RESET), {"csa ", when});
  endtask

  // INR and its store first, IOX and HLT last, random body with forward jumps
  task automatic build_program(input int n);
    int          a;
    int          i;
    logic [11:0] slot;
    logic [15:0] word;
    for (a = 0; a < 4096; a++)
      image[a] = {4'h0, 12'(a)};  // Opcode 0 runs as a no-op
    for (a = 0; a < DATA_WORDS; a++)
      image[DATA_BASE + a] = 16'($urandom);
    image[`ND_PC_RESET] = {OP_IOG, IO_INR, 8'h00};
    image[`ND_PC_RESET + 1] = {OP_STA, RESULT_SLOT};
    for (i = 2; i < n - 2; i++)
    begin
      slot = 12'(DATA_BASE + $urandom_range(DATA_WORDS - 1, 0));
      case ($urandom_range(9, 0))
        0: word = {OP_LDA, slot};
        1, 2: word = {OP_STA, slot};
        3: word = {OP_ADD, slot};  // Random data, sums wrap often
        4: word = {OP_AND, slot};
        5: word = {OP_JMP, 12'(`ND_PC_RESET + $urandom_range(n - 1, i + 1))};
        6: word = {OP_IOG, IO_LDI, 8'($urandom)};
        7: word = {OP_IOG, IO_INR, 8'($urandom)};
        8: word = {OP_IOG, IO_IOX, 8'h00};
        default: word = {4'($urandom_range(14, 6)), 12'($urandom)};  // Unused opcode
      endcase
      image[`ND_PC_RESET + i] = word;
    end
    image[`ND_PC_RESET + n - 2] = {OP_IOG, IO_IOX, 8'h00};
    image[`ND_PC_RESET + n - 1] = {OP_IOG, IO_HLT, 8'h00};
  endtask

  // Instruction set interpreter, fills the expected queues, returns the HLT address
  function automatic logic [11:0] nd_ref_run();
    logic [15:0] m [0:4095];
    instr_u      w;
    logic [15:0] acc;
    logic [11:0] pc;
    logic [11:0] halt_pc;
    logic        done;
    int          a;
    int          steps;
    for (a = 0; a < 4096; a++)
      m[a] = image[a];
    acc      = 16'h0000;
    pc       = `ND_PC_RESET;
    halt_pc  = pc;
    exp_lamp = 5'd0;
    done     = 1'b0;
    steps    = 0;
    while (!done && steps < 4096)
    begin
      exp_addr.push_back(pc);  // Fetch
      w = instr_u'(m[pc]);
      case (w.mem.op)
        OP_LDA:
        begin
          exp_addr.push_back(w.mem.addr);
          acc = m[w.mem.addr];
        end
        OP_STA:
        begin
          exp_addr.push_back(w.mem.addr);
          exp_wr_addr.push_back(w.mem.addr);
          exp_wr_data.push_back(acc);
          m[w.mem.addr] = acc;
        end
        OP_ADD:
        begin
          exp_addr.push_back(w.mem.addr);
          acc = acc + m[w.mem.addr];
        end
        OP_AND:
        begin
          exp_addr.push_back(w.mem.addr);
          acc = acc & m[w.mem.addr];
        end
        OP_IOG:
        begin
          case (w.io.sub)
            IO_LDI: acc = {8'h00, w.io.imm};
            IO_INR: acc = {8'h00, `ND_INSTALL_NUM};
            IO_IOX: exp_lamp = acc[4:0];
            IO_HLT:
            begin
              done    = 1'b1;
              halt_pc = pc;
            end
            default: ;
          endcase
        end
        default: ;
      endcase
      if (w.mem.op == OP_JMP)
        pc = w.mem.addr;
      else
        pc = pc + 12'd1;
      steps++;
    end
    return halt_pc;
  endfunction

  // Memory model, answers after 0 to MAX_DELAY stall cycles
  always @(posedge sysclk)
  begin
    if (rst)
    begin
      for (int a = 0; a < 4096; a++)
        mem[a] = image[a];  // Load the next program
      cyc_busy = 1'b0;
      bdry_n_in <= 1'b1;
      bd_n_in   <= '1;
    end
    else
    begin
      bdry_n_in <= 1'b1;
      bd_n_in   <= '1;
      if (!bdry_n_in && !cyc_read)  // Master takes the write now
      begin
        check_eq(32'(bdap_n_out), 32'd0, "bdap_n_out low while write data is taken");
        mem[cyc_addr] = ~bd_n_out[15:0];
        seen_wr_addr.push_back(cyc_addr);
        seen_wr_data.push_back(~bd_n_out[15:0]);
      end
      if (!bapr_n_out)
      begin
        check_eq(32'(bd_n_out[`ND_BUS_W-1:12]), 32'hFFF, "upper address bits zero");
        check_eq(32'(bmem_n), 32'd0, "bmem_n low with the address");
        cyc_addr = ~bd_n_out[11:0];
        cyc_read = !binput_n;
        cyc_wait = $urandom_range(MAX_DELAY, 0);
        cyc_busy = 1'b1;
        bapr_count++;
        seen_addr.push_back(cyc_addr);
      end
      if (cyc_busy)
      begin
        if (cyc_wait == 0)
        begin
          bdry_n_in <= 1'b0;
          if (cyc_read)
            bd_n_in <= ~{{(`ND_BUS_W-16){1'b0}}, mem[cyc_addr]};
          cyc_busy = 1'b0;
        end
        else
        begin
          cyc_wait--;  // Back-pressure
        end
      end
    end
  end

  // Compare logged bus traffic against the reference
  always @(posedge sysclk)
  begin
    if (!rst)
    begin
      check_eq(32'(led[1]), 32'(bmem_n), "led bit 1 follows bus activity");
      if (seen_addr.size() > 0)
      begin
        if (exp_addr.size() == 0)
          fail_run("Bus address cycle seen after the end of the reference trace");
        else
          check_eq(32'(seen_addr.pop_front()), 32'(exp_addr.pop_front()), "bus address");
      end
      if (seen_wr_addr.size() > 0)
      begin
        if (exp_wr_addr.size() == 0)
          fail_run("Bus write seen that the reference program never makes");
        else
        begin
          check_eq(32'(seen_wr_addr.pop_front()), 32'(exp_wr_addr.pop_front()),
                   "store address");
          check_eq(32'(seen_wr_data.pop_front()), 32'(exp_wr_data.pop_front()),
                   "store data");
        end
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the programs did not finish", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $fatal(1, "Timeout");
  end

  initial
  begin
    int          prog;
    int          n;
    int          cycles;
    int          count_at_halt;
    logic [11:0] halt_next;
    logic [4:0]  lamp_n;
    void'($urandom(23705));
    rst       = 1'b1;
    bapr_n_in = 1'b1;  // Unused pins, held idle
    bdap_n_in = 1'b1;
    for (prog = 0; prog < N_PROGS; prog++)
    begin
      n = $urandom_range(MAX_INSTR, MIN_INSTR);
      build_program(n);
      exp_halt_pc = nd_ref_run();
      @(posedge sysclk);
      rst <= 1'b1;
      repeat (RESET_CYCLES) @(posedge sysclk);
      check_reset_outputs("during reset");
      rst <= 1'b0;
      @(posedge sysclk);
      check_reset_outputs("right after reset");
      cycles = 0;
      while (run_n !== 1'b1 && cycles < HALT_LIMIT)
      begin
        @(posedge sysclk);
        cycles++;
      end
      if (run_n !== 1'b1)
        fail_run($sformatf("Program %0d: CPU did not halt within %0d cycles",
                           prog, HALT_LIMIT));
      count_at_halt = bapr_count;
      repeat (IDLE_CHECK) @(posedge sysclk);
      check_eq(32'(bapr_count), 32'(count_at_halt), "no address cycles after halt");
      halt_next = exp_halt_pc + 12'd1;
      lamp_n    = ~exp_lamp;  // LEDs are active low
      check_eq(32'(csa), 32'(halt_next), "csa after halt");
      check_eq(32'(led[6:2]), 32'(lamp_n), "lamp LEDs after halt");
      check_eq(32'(led[0]), 32'd1, "run LED after halt");
      if (exp_addr.size() != 0 || exp_wr_addr.size() != 0)
        fail_run($sformatf("Program %0d: %0d bus addresses and %0d writes never appeared",
                           prog, exp_addr.size(), exp_wr_addr.size()));
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
source/nd_bus_pkg.sv
source/nd_cpu_pkg.sv
source/nd_decode.sv
source/nd_bus_master.sv
source/nd_execute.sv
source/nd_result.sv
source/nd3202d_board.sv
source/nd120_top.sv
tests/tb_nd120.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_nd120
FILELIST = all.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(wildcard source/*.sv) $(wildcard tests/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
